//--- rtl/fp16_packer.sv
`include "fp16_sqrt_config.svh"

module fp16_packer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          special_done,
    input  logic                          root_done,
    input  fp16_sqrt_pkg::fp16_t          special_result,
    input  logic [`SQRT_ROOT_W-1:0]       root,
    input  logic signed [`SQRT_EXP_W-1:0] exp_q,
    output logic [15:0]                   result,
    output logic                          result_valid
);
    fp16_sqrt_pkg::fp16_t          result_q;
    logic signed [`SQRT_EXP_W-1:0] exp_biased;

    assign exp_biased = exp_q + `FP16_EXP_BIAS;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_q     <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= special_done | root_done;
            if (special_done) begin
                result_q <= special_result;
            end else if (root_done) begin
                result_q.fields.sign <= 1'b0;
                result_q.fields.exp  <= exp_biased[4:0];
                result_q.fields.frac <= root[9:0]; // Truncated, hidden bit dropped.
            end
        end
    end

    assign result = result_q.raw;

    exp_in_normal_range: assert property (@(posedge clk) disable iff (!rst_n)
        root_done |-> (exp_biased >= 7'sd1 && exp_biased <= 7'sd30))
        else $error("biased root exponent out of normal range");

    root_normalized: assert property (@(posedge clk) disable iff (!rst_n)
        root_done |-> root[10])
        else $error("root is not normalized");

endmodule

//--- rtl/fp16_special_handler.sv
`include "fp16_sqrt_config.svh"

module fp16_special_handler (
    input  fp16_sqrt_pkg::fp16_t operand,
    output logic                 is_special,
    output fp16_sqrt_pkg::fp16_t special_result
);
    logic exp_zero;
    logic exp_max;
    logic frac_zero;
    logic is_zero;
    logic is_nan;
    logic is_inf;
    logic is_neg;

    assign exp_zero  = (operand.fields.exp == 5'd0);
    assign exp_max   = (operand.fields.exp == `FP16_EXP_MAX);
    assign frac_zero = (operand.fields.frac == 10'd0);

    assign is_zero = exp_zero & frac_zero;
    assign is_nan  = exp_max & ~frac_zero;
    assign is_inf  = exp_max & frac_zero;
    assign is_neg  = operand.fields.sign & ~is_zero & ~is_nan; // Includes -inf.

    assign is_special = is_zero | is_nan | is_inf | is_neg;

    always_comb begin
        special_result = operand; // Signed zero passes through.
        if (is_nan) begin
            special_result.fields.frac = operand.fields.frac | `FP16_QUIET_BIT;
        end else if (is_neg) begin
            special_result.raw = `FP16_QNAN;
        end else if (is_inf) begin
            special_result.raw = `FP16_PINF;
        end
    end

endmodule

//--- rtl/fp16_sqrt.sv
`include "fp16_sqrt_config.svh"

module fp16_sqrt (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  fp16_sqrt_pkg::fp16_t operand,
    output logic [15:0]          result,
    output logic                 result_valid
);
    logic                          is_special;
    fp16_sqrt_pkg::fp16_t          special_result;
    logic [`SQRT_ROOT_W-1:0]       mant_prepared;
    logic signed [`SQRT_EXP_W-1:0] exp_halved;
    logic                          special_done;
    logic                          root_done;
    logic [`SQRT_ROOT_W-1:0]       root;
    logic signed [`SQRT_EXP_W-1:0] exp_q;

    fp16_special_handler fp16_special_handler_inst (
        .operand        (operand),
        .is_special     (is_special),
        .special_result (special_result)
    );

    fp16_sqrt_prepare fp16_sqrt_prepare_inst (
        .operand       (operand),
        .mant_prepared (mant_prepared),
        .exp_halved    (exp_halved)
    );

    sqrt_controller sqrt_controller_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .enable        (enable),
        .is_special    (is_special),
        .mant_prepared (mant_prepared),
        .exp_halved    (exp_halved),
        .special_done  (special_done),
        .root_done     (root_done),
        .root          (root),
        .exp_q         (exp_q)
    );

    fp16_packer fp16_packer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .special_done   (special_done),
        .root_done      (root_done),
        .special_result (special_result),
        .root           (root),
        .exp_q          (exp_q),
        .result         (result),
        .result_valid   (result_valid)
    );

endmodule

//--- rtl/fp16_sqrt_config.svh
`ifndef FP16_SQRT_CONFIG_SVH
`define FP16_SQRT_CONFIG_SVH

// FP16 format constants.
`define FP16_EXP_BIAS   7'sd15
`define FP16_EXP_MAX    5'h1f
`define FP16_QUIET_BIT  10'h200
`define FP16_QNAN       16'hfe00
`define FP16_PINF       16'h7c00

// Square root datapath.
`define SQRT_ITERATIONS 11
`define SQRT_ITER_W     4
`define SQRT_EXP_W      7
`define SQRT_MANT_W     11
`define SQRT_ROOT_W     12
`define SQRT_REM_W      23
`define SQRT_RAD_W      34

`endif

//--- rtl/fp16_sqrt_pkg.sv
package fp16_sqrt_pkg;

    // IEEE 754 binary16 field layout.
    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] frac;
    } fp16_fields_t;

    // One FP16 word, seen as raw bits or as fields.
    typedef union packed {
        logic [15:0]  raw;
        fp16_fields_t fields;
    } fp16_t;

endpackage

//--- rtl/fp16_sqrt_prepare.sv
`include "fp16_sqrt_config.svh"

module fp16_sqrt_prepare (
    input  fp16_sqrt_pkg::fp16_t           operand,
    output logic [`SQRT_ROOT_W-1:0]        mant_prepared,
    output logic signed [`SQRT_EXP_W-1:0]  exp_halved
);
    logic [3:0]                    clz;
    logic                          is_subnormal;
    logic [`SQRT_MANT_W-1:0]       mant_norm;
    logic [`SQRT_MANT_W-1:0]       mant_sub;
    logic signed [`SQRT_EXP_W-1:0] exp_unbiased;
    logic signed [`SQRT_EXP_W-1:0] exp_norm;
    logic signed [`SQRT_EXP_W-1:0] exp_sub;
    logic signed [`SQRT_EXP_W-1:0] exp_adjusted;
    logic                          exp_odd;

    // Leading zeros of the fraction, 10 when it is all zero.
    always_comb begin
        clz = 4'd10;
        for (int i = 0; i < 10; i++) begin
            if (operand.fields.frac[i]) begin
                clz = 4'(9 - i);
            end
        end
    end

    assign is_subnormal = (operand.fields.exp == 5'd0);

    // Normal path.
    assign exp_norm = $signed({2'b00, operand.fields.exp}) - `FP16_EXP_BIAS;

    // Subnormal path shifts the leading one into the hidden position.
    assign mant_sub = {1'b0, operand.fields.frac} << (clz + 4'd1);
    assign exp_sub  = -`FP16_EXP_BIAS - $signed({3'b000, clz});

    always_comb begin
        if (is_subnormal) begin
            mant_norm    = mant_sub;
            exp_unbiased = exp_sub;
        end else begin
            mant_norm    = {1'b1, operand.fields.frac};
            exp_unbiased = exp_norm;
        end
    end

    // Make the exponent even before halving.
    assign exp_odd = exp_unbiased[0];

    always_comb begin
        if (exp_odd) begin
            mant_prepared = {mant_norm, 1'b0};
            exp_adjusted  = exp_unbiased - 7'sd1;
        end else begin
            mant_prepared = {1'b0, mant_norm};
            exp_adjusted  = exp_unbiased;
        end
    end

    assign exp_halved = exp_adjusted >>> 1; // Exact, value is even.

endmodule

//--- rtl/sqrt_controller.sv
`include "fp16_sqrt_config.svh"

module sqrt_controller (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          enable,
    input  logic                          is_special,
    input  logic [`SQRT_ROOT_W-1:0]       mant_prepared,
    input  logic signed [`SQRT_EXP_W-1:0] exp_halved,
    output logic                          special_done,
    output logic                          root_done,
    output logic [`SQRT_ROOT_W-1:0]       root,
    output logic signed [`SQRT_EXP_W-1:0] exp_q
);
    localparam logic [`SQRT_ITER_W-1:0] ITER_LOAD = `SQRT_ITERATIONS;
    localparam logic [`SQRT_ITER_W-1:0] ITER_LAST = 1;

    logic                    prev_enable;
    logic                    start;
    logic                    start_root;
    logic                    active;
    logic [`SQRT_ITER_W-1:0] iter_cnt;
    logic [`SQRT_ROOT_W-1:0] root_q;
    logic [`SQRT_REM_W-1:0]  rem_q;
    logic [`SQRT_RAD_W-1:0]  rad_q;
    logic [`SQRT_ROOT_W-1:0] root_step;
    logic [`SQRT_REM_W-1:0]  rem_step;
    logic [`SQRT_RAD_W-1:0]  rad_step;

    assign start      = enable & ~prev_enable;
    assign start_root = start & ~is_special;

    sqrt_iteration_core sqrt_iteration_core_inst (
        .root           (root_q),
        .remainder      (rem_q),
        .radicand       (rad_q),
        .root_next      (root_step),
        .remainder_next (rem_step),
        .radicand_next  (rad_step)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_enable  <= 1'b0;
            active       <= 1'b0;
            iter_cnt     <= '0;
            special_done <= 1'b0;
            root_done    <= 1'b0;
        end else if (!enable) begin
            prev_enable  <= 1'b0; // Abort.
            active       <= 1'b0;
            iter_cnt     <= '0;
            special_done <= 1'b0;
            root_done    <= 1'b0;
        end else begin
            prev_enable  <= 1'b1;
            special_done <= start & is_special;
            root_done    <= active && (iter_cnt == ITER_LAST);
            if (start_root) begin
                active   <= 1'b1;
                iter_cnt <= ITER_LOAD;
            end else if (active) begin
                iter_cnt <= iter_cnt - 1'b1;
                if (iter_cnt == ITER_LAST) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // Datapath registers.
    always_ff @(posedge clk) begin
        if (start_root) begin
            root_q <= '0;
            rem_q  <= '0;
            rad_q  <= {mant_prepared, {(`SQRT_RAD_W - `SQRT_ROOT_W){1'b0}}};
            exp_q  <= exp_halved;
        end else if (active) begin
            root_q <= root_step;
            rem_q  <= rem_step;
            rad_q  <= rad_step;
        end
    end

    assign root = root_q;

    cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        iter_cnt <= ITER_LOAD)
        else $error("iteration counter out of range");

    active_has_count: assert property (@(posedge clk) disable iff (!rst_n)
        active |-> (iter_cnt != '0))
        else $error("active with zero iteration count");

    done_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(special_done && root_done))
        else $error("special and root done together");

endmodule

//--- rtl/sqrt_iteration_core.sv
`include "fp16_sqrt_config.svh"

module sqrt_iteration_core (
    input  logic [`SQRT_ROOT_W-1:0] root,
    input  logic [`SQRT_REM_W-1:0]  remainder,
    input  logic [`SQRT_RAD_W-1:0]  radicand,
    output logic [`SQRT_ROOT_W-1:0] root_next,
    output logic [`SQRT_REM_W-1:0]  remainder_next,
    output logic [`SQRT_RAD_W-1:0]  radicand_next
);
    logic [`SQRT_REM_W-1:0] trial;
    logic [`SQRT_REM_W-1:0] rem_shifted;
    logic                   can_subtract;

    // Trial value is 4*root + 1.
    assign trial = {{(`SQRT_REM_W - `SQRT_ROOT_W - 1){1'b0}},
                    root[`SQRT_ROOT_W-2:0], 2'b01};

    // Bring down the next radicand digit pair.
    assign rem_shifted = {remainder[`SQRT_REM_W-3:0],
                          radicand[`SQRT_RAD_W-1:`SQRT_RAD_W-2]};

    assign can_subtract = (rem_shifted >= trial);

    assign root_next      = {root[`SQRT_ROOT_W-2:0], can_subtract};
    assign remainder_next = can_subtract ? rem_shifted - trial : rem_shifted;
    assign radicand_next  = {radicand[`SQRT_RAD_W-3:0], 2'b00};

endmodule

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and decide the outcome from the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module fp16_sqrt_tb -o fp16_sqrt_sim \
    && ./obj_dir/fp16_sqrt_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log \
    && echo "run.sh: simulation OK" \
    || { echo "run.sh: simulation did not pass"; exit 1; }

//--- sources.f
+incdir+rtl
rtl/fp16_sqrt_pkg.sv
rtl/fp16_special_handler.sv
rtl/fp16_sqrt_prepare.sv
rtl/sqrt_iteration_core.sv
rtl/sqrt_controller.sv
rtl/fp16_packer.sv
rtl/fp16_sqrt.sv
tests/clock_gen.sv
tests/fp16_sqrt_tb.sv

//--- tests/clock_gen.sv
module clock_gen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk; // Free running.
    end

endmodule

//--- tests/fp16_sqrt_tb.sv
module fp16_sqrt_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_OPS      = NUM_RANDOM + 20;
    localparam int WATCHDOG_CYC = NUM_OPS * 20 + 200;
    // Edges from the start edge to the rise of result_valid.
    localparam int LAT_SPECIAL  = 1;
    localparam int LAT_ROOT     = 12;

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic [15:0] operand;
    logic [15:0] result;
    logic        result_valid;

    int          seed           = 32'hf5c3_14be;
    int          edge_cnt       = 0;
    int          due_edge       = 0;
    logic        op_pending     = 1'b0;
    logic [15:0] expected_value = 16'h0000;
    logic [15:0] last_result    = 16'h0000;

    clock_gen #(.PERIOD(CLK_PERIOD)) clock_gen_inst (.clk(clk));

    fp16_sqrt fp16_sqrt_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (enable),
        .operand      (operand),
        .result       (result),
        .result_valid (result_valid)
    );

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic report_failure();
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Zero, NaN, infinity or any negative value.
    function automatic logic special_operand(input logic [15:0] x);
        return (x[14:0] == 15'd0) || (x[14:10] == 5'h1f) || x[15];
    endfunction

    function automatic int isqrt(input int n);
        int r;
        r = 0;
        while ((r + 1) * (r + 1) <= n) begin
            r++;
        end
        return r;
    endfunction

    // Expected root of a positive finite nonzero operand, fraction truncated.
    function automatic logic [15:0] model_root(input logic [15:0] x);
        int mant;
        int e;
        int r;
        if (x[14:10] == 5'd0) begin
            mant = int'(x[9:0]);
            e    = -14;
            while (mant < 1024) begin
                mant = mant * 2;
                e    = e - 1;
            end
        end else begin
            mant = 1024 + int'(x[9:0]);
            e    = int'(x[14:10]) - 15;
        end
        if (e % 2 != 0) begin
            mant = mant * 2;
            e    = e - 1;
        end
        r = isqrt(mant * 1024); // Root lands in [1024, 2048).
        return {1'b0, 5'(e / 2 + 15), 10'(r)};
    endfunction

    task automatic run_op(input logic [15:0] x, input logic [15:0] want);
        @(negedge clk);
        operand        = x;
        expected_value = want;
        due_edge       = edge_cnt + 1 + (special_operand(x) ? LAT_SPECIAL : LAT_ROOT);
        op_pending     = 1'b1;
        enable         = 1'b1;
        do begin
            @(negedge clk);
        end while (!result_valid);
        last_result = want;
        enable      = 1'b0;
        @(negedge clk); // Let the strobe be sampled first.
        op_pending = 1'b0;
    endtask

    // Start a computation and drop enable before it can finish.
    task automatic abort_op(input logic [15:0] x, input int run_cycles);
        @(negedge clk);
        operand = x;
        enable  = 1'b1;
        repeat (run_cycles) @(negedge clk);
        enable = 1'b0;
        repeat (LAT_ROOT + 4) @(negedge clk);
    endtask

    valid_when_due: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (op_pending && edge_cnt == due_edge))
        else begin
            $display("ERROR: result_valid = %h, expected %h", $sampled(result_valid), 1'b0);
            report_failure();
        end

    valid_not_missed: assert property (@(posedge clk) disable iff (!rst_n)
        (op_pending && edge_cnt == due_edge) |-> result_valid)
        else begin
            $display("ERROR: result_valid = %h, expected %h", $sampled(result_valid), 1'b1);
            report_failure();
        end

    result_matches: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (result == expected_value))
        else begin
            $display("ERROR: result = %h, expected %h", $sampled(result), expected_value);
            report_failure();
        end

    // Covers the reset value and the hold after an abort.
    result_holds: assert property (@(posedge clk) disable iff (!rst_n)
        !result_valid |-> (result == last_result))
        else begin
            $display("ERROR: result = %h, expected %h", $sampled(result), last_result);
            report_failure();
        end

    valid_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |=> !result_valid)
        else begin
            $display("ERROR: result_valid = %h, expected %h", $sampled(result_valid), 1'b0);
            report_failure();
        end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Timeout: the test sequence did not finish within %0d cycles", WATCHDOG_CYC);
        report_failure();
    end

    initial begin
        logic [15:0] x;
        int          i;

        rst_n   = 1'b0;
        enable  = 1'b0;
        operand = 16'h0000;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        run_op(16'h0000, 16'h0000);
        run_op(16'h8000, 16'h8000);
        run_op(16'h7c00, 16'h7c00);
        run_op(16'hfc00, 16'hfe00);
        run_op(16'h7c01, 16'h7e01); // Signaling NaN gets quieted.
        run_op(16'hfd55, 16'hff55);
        run_op(16'h7e00, 16'h7e00);
        run_op(16'hc400, 16'hfe00);
        run_op(16'h8001, 16'hfe00);

        run_op(16'h4400, 16'h4000);
        run_op(16'h3c00, 16'h3c00);
        run_op(16'h4080, 16'h3e00);
        run_op(16'h3400, 16'h3800);

        abort_op(16'h4d00, 5);

        run_op(16'h0001, model_root(16'h0001));
        run_op(16'h03ff, model_root(16'h03ff));
        run_op(16'h7bff, model_root(16'h7bff));

        for (i = 0; i < NUM_RANDOM; i++) begin
            x      = 16'($random(seed));
            x[15]  = 1'b0;
            if (i % 2 == 0) begin
                x[14:10] = 5'd0; // Subnormal.
            end
            if (x[14:10] == 5'h1f) begin
                x[14:10] = 5'h1e;
            end
            if (x[14:0] == 15'd0) begin
                x[0] = 1'b1;
            end
            run_op(x, model_root(x));
        end

        // Dropped on the last iteration.
        abort_op(16'h5a3c, LAT_ROOT - 1);
        run_op(16'h4880, model_root(16'h4880));

        repeat (4) @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule
